// ==== rtl/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

    //////////////////////////////////////////////////////////////////////////////
    // data and address shapes
    //////////////////////////////////////////////////////////////////////////////

    // one machine word on this core
    localparam int unsigned xlen = 32;

    typedef logic [xlen-1:0] csr_word_t;
    typedef logic [11:0]     csr_addr_t;

    // the four machine-mode CSRs that are implemented
    localparam csr_addr_t addr_mstatus = 12'h300;
    localparam csr_addr_t addr_mtvec   = 12'h305;
    localparam csr_addr_t addr_mepc    = 12'h341;
    localparam csr_addr_t addr_mcause  = 12'h342;

    // write style of a Zicsr op
    // the codes follow funct3[1:0], so 00 is never a CSR op
    typedef enum logic [1:0] {
        op_rw = 2'b01,
        op_rs = 2'b10,
        op_rc = 2'b11
    } csr_op_e;

    //////////////////////////////////////////////////////////////////////////////
    // mstatus fields
    //////////////////////////////////////////////////////////////////////////////

    localparam int unsigned mstatus_mie_bit  = 3;
    localparam int unsigned mstatus_mpie_bit = 7;

    // MPP in bits 12:11 is tied to machine mode, everything else starts at zero
    localparam csr_word_t mstatus_reset = 32'h0000_1800;

    // only MIE and MPIE can be changed by software
    localparam csr_word_t mstatus_wmask = (csr_word_t'(1) << mstatus_mie_bit)
                                        | (csr_word_t'(1) << mstatus_mpie_bit);

endpackage

`default_nettype wire

// ==== rtl/trap_pkg.sv ====
`default_nettype none

package trap_pkg;

    // what a retiring instruction asks of the CSR unit
    // ecall and mret are handled here as well as the Zicsr ops
    typedef enum logic [1:0] {
        kind_csr   = 2'd0,
        kind_ecall = 2'd1,
        kind_mret  = 2'd2
    } req_kind_e;

    // mcause code for an environment call from machine mode
    localparam logic [31:0] cause_ecall_m = 32'd11;

    // the two mode bits of mtvec are kept in the register
    // but the redirect only ever goes to the base address
    localparam logic [31:0] mtvec_base_mask = 32'hffff_fffc;

endpackage

`default_nettype wire

// ==== rtl/csr_req_if.sv ====
`timescale 1ns/1ps
`default_nettype none

////////////////////////////////////////////////////////////////////////////////
// decoded request, decoder to register file
////////////////////////////////////////////////////////////////////////////////

interface csr_req_if
    import csr_pkg::*, trap_pkg::*;
;
    // valid lasts one cycle and the other fields only mean something with it
    logic      valid;
    req_kind_e kind;
    csr_op_e   op;
    csr_addr_t addr;
    csr_word_t operand;
    // pc of the retiring instruction, used by ecall to fill mepc
    csr_word_t pc;

    modport source (output valid, kind, op, addr, operand, pc);
    modport sink   (input  valid, kind, op, addr, operand, pc);
endinterface

////////////////////////////////////////////////////////////////////////////////
// register file response, register file to result stage
////////////////////////////////////////////////////////////////////////////////

interface csr_rsp_if
    import csr_pkg::*, trap_pkg::*;
;
    // all of this is combinational in the cycle of the request
    logic      valid;
    req_kind_e kind;
    logic      illegal;
    // values as they were before the edge that applies the update
    csr_word_t old_value;
    csr_word_t mtvec;
    csr_word_t mepc;

    modport source (output valid, kind, illegal, old_value, mtvec, mepc);
    modport sink   (input  valid, kind, illegal, old_value, mtvec, mepc);
endinterface

`default_nettype wire

// ==== rtl/csr_cmd_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_cmd_decode
    import csr_pkg::*;
    import trap_pkg::*;
(
    input  logic      instr_valid,
    input  logic [2:0] funct3,
    input  csr_addr_t csr_addr,
    input  csr_word_t rs1_data,
    input  logic [4:0] zimm,
    input  csr_word_t pc,
    input  logic      ecall,
    input  logic      mret,
    csr_req_if.source req
);

    // funct3 000 belongs to ecall/mret and 100 is unused,
    // so only a nonzero low pair marks a Zicsr op
    logic      is_csr;
    csr_op_e   op;
    csr_word_t operand;

    assign is_csr = (funct3[1:0] != 2'b00);

    // low two bits of funct3 pick the write style
    always_comb begin
        case (funct3[1:0])
            2'b01:   op = op_rw;
            2'b10:   op = op_rs;
            2'b11:   op = op_rc;
            default: op = op_rw;
        endcase
    end

    // bit 2 of funct3 selects the immediate forms csrrwi, csrrsi and csrrci
    // where the rs1 field is a zero-extended 5-bit constant
    assign operand = funct3[2] ? {{(xlen-5){1'b0}}, zimm} : rs1_data;

    //////////////////////////////////////////////////////////////////////////////
    // request out
    //////////////////////////////////////////////////////////////////////////////

    // a retiring instruction that is none of the three kinds makes no request
    assign req.valid = instr_valid && (ecall || mret || is_csr);

    // ecall beats mret, and both beat a CSR op
    always_comb begin
        if (ecall) begin
            req.kind = kind_ecall;
        end else if (mret) begin
            req.kind = kind_mret;
        end else begin
            req.kind = kind_csr;
        end
    end

    assign req.op      = op;
    assign req.addr    = csr_addr;
    assign req.operand = operand;
    assign req.pc      = pc;

    // the core never retires one instruction as both an ecall and an mret,
    // the priority above only settles the kind if that contract breaks
    ecall_mret_excl: assert final (!(instr_valid && ecall && mret))
        else $error("ecall and mret raised together on one retiring instruction");

endmodule

`default_nettype wire

// ==== rtl/csr_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_regfile
    import csr_pkg::*;
    import trap_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    csr_req_if.sink   req,
    csr_rsp_if.source rsp
);

    csr_word_t mstatus;
    csr_word_t mtvec;
    csr_word_t mepc;
    csr_word_t mcause;

    logic      hit_mstatus;
    logic      hit_mtvec;
    logic      hit_mepc;
    logic      hit_mcause;
    logic      addr_legal;
    logic      is_csr;
    csr_word_t old_value;
    csr_word_t wdata;

    //////////////////////////////////////////////////////////////////////////////
    // address decode and read side
    //////////////////////////////////////////////////////////////////////////////

    assign hit_mstatus = (req.addr == addr_mstatus);
    assign hit_mtvec   = (req.addr == addr_mtvec);
    assign hit_mepc    = (req.addr == addr_mepc);
    assign hit_mcause  = (req.addr == addr_mcause);
    assign addr_legal  = hit_mstatus || hit_mtvec || hit_mepc || hit_mcause;
    assign is_csr      = (req.kind == kind_csr);

    // an unknown address reads back as zero, the result stage drops it anyway
    always_comb begin
        case (req.addr)
            addr_mstatus: old_value = mstatus;
            addr_mtvec:   old_value = mtvec;
            addr_mepc:    old_value = mepc;
            addr_mcause:  old_value = mcause;
            default:      old_value = '0;
        endcase
    end

    // read-modify-write value, taken from the register before the edge
    always_comb begin
        case (req.op)
            op_rw:   wdata = req.operand;
            op_rs:   wdata = old_value | req.operand;
            op_rc:   wdata = old_value & ~req.operand;
            default: wdata = old_value;
        endcase
    end

    assign rsp.valid     = req.valid;
    assign rsp.kind      = req.kind;
    assign rsp.illegal   = is_csr && !addr_legal;
    assign rsp.old_value = old_value;
    assign rsp.mtvec     = mtvec;
    assign rsp.mepc      = mepc;

    //////////////////////////////////////////////////////////////////////////////
    // state update
    //////////////////////////////////////////////////////////////////////////////

    // everything lands at the edge that captures the request,
    // so a request in the following cycle already reads the new values
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mstatus <= mstatus_reset;
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
        end else if (req.valid) begin
            case (req.kind)
                kind_ecall: begin
                    // trap entry saves the pc and stacks the interrupt enable
                    mepc                      <= {req.pc[xlen-1:2], 2'b00};
                    mcause                    <= cause_ecall_m;
                    mstatus[mstatus_mpie_bit] <= mstatus[mstatus_mie_bit];
                    mstatus[mstatus_mie_bit]  <= 1'b0;
                end
                kind_mret: begin
                    // return pops the stacked enable and leaves MPIE set
                    mstatus[mstatus_mie_bit]  <= mstatus[mstatus_mpie_bit];
                    mstatus[mstatus_mpie_bit] <= 1'b1;
                end
                default: begin
                    // an illegal address hits nothing here, so nothing is written
                    if (hit_mstatus) begin
                        mstatus <= (wdata & mstatus_wmask) | (mstatus_reset & ~mstatus_wmask);
                    end
                    // mode bits of mtvec are kept as written
                    if (hit_mtvec) begin
                        mtvec <= wdata;
                    end
                    // instructions are word aligned, the low pair of mepc stays zero
                    if (hit_mepc) begin
                        mepc <= {wdata[xlen-1:2], 2'b00};
                    end
                    if (hit_mcause) begin
                        mcause <= wdata;
                    end
                end
            endcase
        end
    end

    // MPP must stay in machine mode through writes, traps and returns
    mpp_fixed: assert property (@(posedge clk) disable iff (!rst_n)
        mstatus[12:11] == 2'b11)
        else $error("mstatus MPP left machine mode");

    // mepc is aligned whether it came from a CSR write or from a trap pc
    mepc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        mepc[1:0] == 2'b00)
        else $error("mepc holds a misaligned address");

endmodule

`default_nettype wire

// ==== rtl/csr_result_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_result_stage
    import csr_pkg::*;
    import trap_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    csr_rsp_if.sink   rsp,
    output logic      rd_valid,
    output csr_word_t rd_data,
    output logic      illegal,
    output logic      redirect_valid,
    output csr_word_t redirect_pc
);

    logic is_csr;
    logic is_redirect;

    assign is_csr      = rsp.valid && (rsp.kind == kind_csr);
    assign is_redirect = rsp.valid && (rsp.kind != kind_csr);

    //////////////////////////////////////////////////////////////////////////////
    // one-cycle strobes
    //////////////////////////////////////////////////////////////////////////////

    // each strobe is high for exactly the cycle after its request
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_valid       <= 1'b0;
            illegal        <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            rd_valid       <= is_csr && !rsp.illegal;
            illegal        <= is_csr && rsp.illegal;
            redirect_valid <= is_redirect;
        end
    end

    //////////////////////////////////////////////////////////////////////////////
    // data held with the strobes
    //////////////////////////////////////////////////////////////////////////////

    // old CSR value goes back to the core for rd
    always_ff @(posedge clk) begin
        if (is_csr) begin
            rd_data <= rsp.old_value;
        end
    end

    // ecall jumps to the trap base, mret goes back to the saved pc
    always_ff @(posedge clk) begin
        if (is_redirect) begin
            if (rsp.kind == kind_ecall) begin
                redirect_pc <= rsp.mtvec & mtvec_base_mask;
            end else begin
                redirect_pc <= rsp.mepc;
            end
        end
    end

    // one request yields exactly one kind of result
    one_result: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({rd_valid, illegal, redirect_valid}))
        else $error("more than one result strobe raised in a cycle");

endmodule

`default_nettype wire

// ==== rtl/csr_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_unit
    import csr_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    // retiring instruction from the core
    input  logic       instr_valid,
    input  logic [2:0] funct3,
    input  csr_addr_t  csr_addr,
    input  csr_word_t  rs1_data,
    input  logic [4:0] zimm,
    input  csr_word_t  pc,
    input  logic       ecall,
    input  logic       mret,
    // results, one cycle after the request
    output logic       rd_valid,
    output csr_word_t  rd_data,
    output logic       illegal,
    output logic       redirect_valid,
    output csr_word_t  redirect_pc
);

    csr_req_if req_bus ();
    csr_rsp_if rsp_bus ();

    // decode is combinational and feeds the register file in the same cycle
    csr_cmd_decode u_decode (
        .instr_valid (instr_valid),
        .funct3      (funct3),
        .csr_addr    (csr_addr),
        .rs1_data    (rs1_data),
        .zimm        (zimm),
        .pc          (pc),
        .ecall       (ecall),
        .mret        (mret),
        .req         (req_bus.source)
    );

    csr_regfile u_regfile (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req_bus.sink),
        .rsp   (rsp_bus.source)
    );

    // the only pipeline register between request and result
    csr_result_stage u_result (
        .clk            (clk),
        .rst_n          (rst_n),
        .rsp            (rsp_bus.sink),
        .rd_valid       (rd_valid),
        .rd_data        (rd_data),
        .illegal        (illegal),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

`default_nettype wire

// ==== sim/csr_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_unit_tb
    import csr_pkg::*;
    import trap_pkg::*;
;
    // which strobe a request is expected to raise one cycle later
    localparam logic [1:0] res_rd    = 2'd0;
    localparam logic [1:0] res_ill   = 2'd1;
    localparam logic [1:0] res_redir = 2'd2;

    typedef struct packed {
        req_kind_e  kind;
        logic [2:0] funct3;
        csr_addr_t  addr;
        csr_word_t  operand;
        csr_word_t  pc;
        logic [1:0] res;
        csr_word_t  value;
    } row_t;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       instr_valid;
    logic [2:0] funct3;
    csr_addr_t  csr_addr;
    csr_word_t  rs1_data;
    logic [4:0] zimm;
    csr_word_t  pc;
    logic       ecall;
    logic       mret;
    logic       rd_valid;
    csr_word_t  rd_data;
    logic       illegal;
    logic       redirect_valid;
    csr_word_t  redirect_pc;

    row_t      rows [0:31];
    int        n_rows;
    integer    seed;
    csr_word_t rnd_mtvec;
    csr_word_t rnd_pc;
    csr_word_t rnd_status;
    // reference model of the state that the random section touches
    csr_word_t m_mtvec;
    csr_word_t m_mepc;
    logic      m_mie;
    logic      m_mpie;

    csr_unit UUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_valid    (instr_valid),
        .funct3         (funct3),
        .csr_addr       (csr_addr),
        .rs1_data       (rs1_data),
        .zimm           (zimm),
        .pc             (pc),
        .ecall          (ecall),
        .mret           (mret),
        .rd_valid       (rd_valid),
        .rd_data        (rd_data),
        .illegal        (illegal),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    always #50 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_word(input string name, input csr_word_t got, input csr_word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0d ns: %s is %h, expected %h", $time, name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "word compare mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0d ns: %s is %b, expected %b", $time, name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "flag compare mismatch");
        end
    endtask

    // exactly the expected strobe is up and its data matches
    task automatic check_result(input logic [1:0] res, input csr_word_t value);
        check_flag("rd_valid", rd_valid, res == res_rd);
        check_flag("illegal", illegal, res == res_ill);
        check_flag("redirect_valid", redirect_valid, res == res_redir);
        if (res == res_rd) begin
            check_word("rd_data", rd_data, value);
        end
        if (res == res_redir) begin
            check_word("redirect_pc", redirect_pc, value);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // driving the core side
    ////////////////////////////////////////////////////////////////////////////

    task automatic drive_idle();
        instr_valid = 1'b0;
        funct3      = 3'b000;
        csr_addr    = '0;
        rs1_data    = '0;
        zimm        = '0;
        pc          = '0;
        ecall       = 1'b0;
        mret        = 1'b0;
    endtask

    // the unused operand source gets the inverse, so a wrong pick shows up
    task automatic drive_request(input req_kind_e kind, input logic [2:0] f3,
                                 input csr_addr_t addr, input csr_word_t operand,
                                 input csr_word_t req_pc);
        instr_valid = 1'b1;
        funct3      = f3;
        csr_addr    = addr;
        rs1_data    = f3[2] ? ~operand : operand;
        zimm        = f3[2] ? operand[4:0] : ~operand[4:0];
        pc          = req_pc;
        ecall       = (kind == kind_ecall);
        mret        = (kind == kind_mret);
    endtask

    task automatic add_row(input req_kind_e kind, input logic [2:0] f3, input csr_addr_t addr,
                           input csr_word_t operand, input csr_word_t req_pc,
                           input logic [1:0] res, input csr_word_t value);
        rows[n_rows] = {kind, f3, addr, operand, req_pc, res, value};
        n_rows++;
    endtask

    function automatic logic pulse_seen(input logic [1:0] res);
        case (res)
            res_rd:  return rd_valid;
            res_ill: return illegal;
            default: return redirect_valid;
        endcase
    endfunction

    // one request on its own, then wait for its strobe
    task automatic run_op(input req_kind_e kind, input logic [2:0] f3, input csr_addr_t addr,
                          input csr_word_t operand, input csr_word_t req_pc,
                          input logic [1:0] res, input csr_word_t value);
        int waited;
        drive_request(kind, f3, addr, operand, req_pc);
        @(posedge clk);
        #5;
        drive_idle();
        waited = 0;
        while (!pulse_seen(res)) begin
            if (waited == 20) begin
                $display("the %s pulse never came within 20 cycles at %0d ns",
                         res == res_rd ? "rd_valid" : (res == res_ill ? "illegal"
                         : "redirect_valid"), $time);
                $display("RESULT: FAIL");
                $fatal(1, "timeout waiting for a result strobe");
            end
            @(posedge clk);
            #5;
            waited++;
        end
        check_result(res, value);
    endtask

    // MPP reads 11, and only MIE and MPIE move
    function automatic csr_word_t mstatus_value(input logic mie, input logic mpie);
        return 32'h0000_1800 | {24'd0, mpie, 3'b000, mie, 3'b000};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        n_rows = 0;
        seed   = 32'hfded;
        rst_n  = 1'b0;
        drive_idle();

        // first touch of each CSR returns its reset value
        add_row(kind_csr, 3'b001, addr_mstatus, 32'hffff_ffff, '0, res_rd, 32'h0000_1800);
        add_row(kind_csr, 3'b011, addr_mstatus, 32'h0000_0080, '0, res_rd, 32'h0000_1888);
        add_row(kind_csr, 3'b110, addr_mepc, 32'h0000_001f, '0, res_rd, 32'h0000_0000);
        add_row(kind_csr, 3'b111, addr_mepc, 32'h0000_0004, '0, res_rd, 32'h0000_001c);
        add_row(kind_csr, 3'b101, addr_mcause, 32'h0000_0005, '0, res_rd, 32'h0000_0000);
        add_row(kind_csr, 3'b001, addr_mtvec, 32'h8000_0103, '0, res_rd, 32'h0000_0000);
        add_row(kind_csr, 3'b010, addr_mtvec, 32'h0000_0000, '0, res_rd, 32'h8000_0103);
        // 340 hex is mscratch, which this unit does not implement
        add_row(kind_csr, 3'b001, 12'h340, 32'hffff_ffff, '0, res_ill, 32'h0000_0000);
        add_row(kind_csr, 3'b010, addr_mstatus, 32'h0000_0000, '0, res_rd, 32'h0000_1808);
        add_row(kind_csr, 3'b010, addr_mtvec, 32'h0000_0000, '0, res_rd, 32'h8000_0103);
        add_row(kind_csr, 3'b010, addr_mepc, 32'h0000_0000, '0, res_rd, 32'h0000_0018);
        add_row(kind_csr, 3'b010, addr_mcause, 32'h0000_0000, '0, res_rd, 32'h0000_0005);
        add_row(kind_ecall, 3'b000, '0, '0, 32'h0000_1236, res_redir, 32'h8000_0100);
        add_row(kind_csr, 3'b010, addr_mepc, 32'h0000_0000, '0, res_rd, 32'h0000_1234);
        add_row(kind_csr, 3'b010, addr_mcause, 32'h0000_0000, '0, res_rd, 32'h0000_000b);
        add_row(kind_csr, 3'b010, addr_mstatus, 32'h0000_0000, '0, res_rd, 32'h0000_1880);
        add_row(kind_mret, 3'b000, '0, '0, '0, res_redir, 32'h0000_1234);
        add_row(kind_csr, 3'b010, addr_mstatus, 32'h0000_0000, '0, res_rd, 32'h0000_1888);

        repeat (2) @(posedge clk);
        #5;
        rst_n = 1'b1;

        // nothing may come out before the first request
        repeat (2) begin
            @(posedge clk);
            #5;
            check_flag("rd_valid", rd_valid, 1'b0);
            check_flag("illegal", illegal, 1'b0);
            check_flag("redirect_valid", redirect_valid, 1'b0);
        end

        // the table goes in back to back, so each row is checked while the next is decoded
        drive_request(rows[0].kind, rows[0].funct3, rows[0].addr, rows[0].operand, rows[0].pc);
        for (int i = 1; i <= n_rows; i++) begin
            @(posedge clk);
            #5;
            check_result(rows[i-1].res, rows[i-1].value);
            if (i < n_rows) begin
                drive_request(rows[i].kind, rows[i].funct3, rows[i].addr, rows[i].operand,
                              rows[i].pc);
            end else begin
                drive_idle();
            end
        end

        // state left behind by the last table rows
        m_mtvec = 32'h8000_0103;
        m_mie   = 1'b1;
        m_mpie  = 1'b1;

        repeat (8) begin
            rnd_mtvec  = $random(seed);
            rnd_pc     = $random(seed);
            rnd_status = $random(seed);
            run_op(kind_csr, 3'b001, addr_mtvec, rnd_mtvec, '0, res_rd, m_mtvec);
            m_mtvec = rnd_mtvec;
            run_op(kind_csr, 3'b001, addr_mstatus, rnd_status, '0, res_rd,
                   mstatus_value(m_mie, m_mpie));
            m_mie  = rnd_status[3];
            m_mpie = rnd_status[7];
            // trap entry jumps to the base with the mode bits dropped
            run_op(kind_ecall, 3'b000, '0, '0, rnd_pc, res_redir, m_mtvec & 32'hffff_fffc);
            m_mepc = {rnd_pc[31:2], 2'b00};
            m_mpie = m_mie;
            m_mie  = 1'b0;
            run_op(kind_csr, 3'b010, addr_mepc, '0, '0, res_rd, m_mepc);
            run_op(kind_csr, 3'b010, addr_mcause, '0, '0, res_rd, 32'd11);
            run_op(kind_csr, 3'b010, addr_mstatus, '0, '0, res_rd, mstatus_value(m_mie, m_mpie));
            run_op(kind_mret, 3'b000, '0, '0, '0, res_redir, m_mepc);
            m_mie  = m_mpie;
            m_mpie = 1'b1;
            run_op(kind_csr, 3'b010, addr_mstatus, '0, '0, res_rd, mstatus_value(m_mie, m_mpie));
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== csr_unit.f ====
rtl/csr_pkg.sv
rtl/trap_pkg.sv
rtl/csr_req_if.sv
rtl/csr_cmd_decode.sv
rtl/csr_regfile.sv
rtl/csr_result_stage.sv
rtl/csr_unit.sv
sim/csr_unit_tb.sv

// ==== Bender.yml ====
package:
  name: csr_unit

sources:
  - files:
      - rtl/csr_pkg.sv
      - rtl/trap_pkg.sv
      - rtl/csr_req_if.sv
      - rtl/csr_cmd_decode.sv
      - rtl/csr_regfile.sv
      - rtl/csr_result_stage.sv
      - rtl/csr_unit.sv

  - target: simulation
    files:
      - sim/csr_unit_tb.sv
